//--- scan_pkg.sv
package scan_pkg;

    ////////////////////
    // Word geometry
    ////////////////////

    // Data and address width
    parameter int word_width = 32;

    // Byte increment between consecutive words
    parameter int addr_step = 4;

    typedef logic [word_width-1:0] word_t;

    typedef logic [word_width-1:0] addr_t;

    // Index of one bit inside a word
    typedef logic [$clog2(word_width)-1:0] bit_ptr_t;

endpackage

//--- mem_req_if.sv
interface mem_req_if;

    // Held steady by the client until done
    logic            req;
    logic            is_read;
    scan_pkg::addr_t addr;
    scan_pkg::word_t wdata;

    // One-cycle completion, rdata valid with it
    scan_pkg::word_t rdata;
    logic            done;

    modport client (
        output req,
        output is_read,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport arbiter (
        input  req,
        input  is_read,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

//--- scan_word_fifo.sv
module scan_word_fifo #(
    parameter int fifo_depth = 2
) (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            push,
    input  scan_pkg::word_t push_word,
    input  logic            pop,
    output scan_pkg::word_t pop_word,
    output logic            full,
    output logic            empty
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    scan_pkg::word_t  mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // Wrap for depths that are not a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == cnt_w'(fifo_depth));
    assign empty    = (count == '0);
    assign pop_word = mem[rd_ptr];

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge aclk or posedge aresetn)
    begin
        if (aresetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- word_fetch.sv
module word_fetch #(
    parameter int fifo_depth = 2
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             run_start,
    input  scan_pkg::addr_t  scan_address_src,
    input  scan_pkg::word_t  scan_length,
    input  logic             in_ready,
    output logic             in_valid,
    output scan_pkg::word_t  in_word,
    mem_req_if.client        mem
);

    localparam int word_shift = $clog2(scan_pkg::word_width);

    scan_pkg::addr_t src_ptr;
    scan_pkg::word_t words_left;
    scan_pkg::word_t words_needed;
    logic            fifo_full;
    logic            fifo_empty;

    // Length in bits, rounded up to whole words
    assign words_needed = (scan_length >> word_shift)
                        + scan_pkg::word_t'(|scan_length[word_shift-1:0]);

    assign mem.is_read = 1'b1;
    assign mem.addr    = src_ptr;
    assign mem.wdata   = '0;

    assign in_valid = !fifo_empty;

    ////////////////////
    // Read requests
    ////////////////////

    // One read in flight at most, so not full leaves room for it
    always_ff @(posedge aclk or posedge aresetn)
    begin
        if (aresetn)
        begin
            mem.req    <= 1'b0;
            words_left <= '0;
        end
        else if (run_start)
        begin
            words_left <= words_needed;
        end
        else if (mem.done)
        begin
            mem.req    <= 1'b0;
            words_left <= words_left - 1'b1;
        end
        else if (!mem.req && words_left != '0 && !fifo_full)
        begin
            mem.req <= 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (run_start)
        begin
            src_ptr <= scan_address_src;
        end
        else if (mem.done)
        begin
            src_ptr <= scan_pkg::addr_t'(src_ptr + scan_pkg::addr_step);
        end
    end

    scan_word_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .push      (mem.done),
        .push_word (mem.rdata),
        .pop       (in_valid && in_ready),
        .pop_word  (in_word),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

endmodule

//--- word_store.sv
module word_store #(
    parameter int fifo_depth = 2
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             run_start,
    input  scan_pkg::addr_t  scan_address_dst,
    input  logic             out_valid,
    input  scan_pkg::word_t  out_word,
    input  logic             out_last,
    output logic             out_ready,
    output logic             scan_done,
    mem_req_if.client        mem
);

    localparam int cnt_w = $clog2(fifo_depth + 1);

    scan_pkg::addr_t  dst_ptr;
    scan_pkg::word_t  head_word;
    logic             fifo_full;
    logic             fifo_empty;
    logic             push;
    logic             last_seen;
    logic [cnt_w-1:0] held;

    assign out_ready = !fifo_full;
    assign push      = out_valid && out_ready;

    assign mem.is_read = 1'b0;
    assign mem.addr    = dst_ptr;
    assign mem.wdata   = head_word;

    always_ff @(posedge aclk or posedge aresetn)
    begin
        if (aresetn)
        begin
            mem.req   <= 1'b0;
            scan_done <= 1'b0;
            last_seen <= 1'b0;
            held      <= '0;
        end
        else
        begin
            if (push && !mem.done)
            begin
                held <= held + 1'b1;
            end
            else if (mem.done && !push)
            begin
                held <= held - 1'b1;
            end

            if (run_start)
            begin
                scan_done <= 1'b0;
                last_seen <= 1'b0;
            end
            else if (push && out_last)
            begin
                last_seen <= 1'b1;
            end

            // Last word is the only one left once it has been queued
            if (mem.done)
            begin
                mem.req <= 1'b0;
                if (last_seen && held == cnt_w'(1))
                begin
                    scan_done <= 1'b1;
                end
            end
            else if (!mem.req && !fifo_empty)
            begin
                mem.req <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (run_start)
        begin
            dst_ptr <= scan_address_dst;
        end
        else if (mem.done)
        begin
            dst_ptr <= scan_pkg::addr_t'(dst_ptr + scan_pkg::addr_step);
        end
    end

    scan_word_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .push      (push),
        .push_word (out_word),
        .pop       (mem.done),
        .pop_word  (head_word),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

endmodule

//--- mem_port_arbiter.sv
module mem_port_arbiter (
    input  logic             aclk,
    input  logic             aresetn,
    input  scan_pkg::word_t  cs_data_i,
    input  logic             cs_done,
    output logic             cs_ready,
    output scan_pkg::addr_t  cs_address,
    output logic             cs_is_read,
    output scan_pkg::word_t  cs_data_o,
    mem_req_if.arbiter       rd_port,
    mem_req_if.arbiter       wr_port
);

    logic busy;
    logic grant_wr;
    logic start;

    assign start = !busy && (rd_port.req || wr_port.req);

    // Completion goes back to the granted client only
    assign rd_port.done  = busy && cs_done && !grant_wr;
    assign wr_port.done  = busy && cs_done && grant_wr;
    assign rd_port.rdata = cs_data_i;
    assign wr_port.rdata = cs_data_i;

    always_ff @(posedge aclk or posedge aresetn)
    begin
        if (aresetn)
        begin
            busy     <= 1'b0;
            grant_wr <= 1'b0;
            cs_ready <= 1'b0;
        end
        else
        begin
            cs_ready <= 1'b0;
            if (start)
            begin
                busy     <= 1'b1;
                cs_ready <= 1'b1;
                // Store first
                grant_wr <= wr_port.req;
            end
            else if (busy && cs_done)
            begin
                busy <= 1'b0;
            end
        end
    end

    // Access held on the port until cs_done
    always_ff @(posedge aclk)
    begin
        if (start)
        begin
            cs_address <= wr_port.req ? wr_port.addr    : rd_port.addr;
            cs_is_read <= wr_port.req ? wr_port.is_read : rd_port.is_read;
            cs_data_o  <= wr_port.req ? wr_port.wdata   : rd_port.wdata;
        end
    end

endmodule

//--- scan_shifter.sv
module scan_shifter (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             scan_start,
    input  scan_pkg::word_t  scan_length,
    input  logic             in_valid,
    input  scan_pkg::word_t  in_word,
    input  logic             out_ready,
    input  logic             scan_output,
    output logic             run_start,
    output logic             in_ready,
    output logic             out_valid,
    output scan_pkg::word_t  out_word,
    output logic             out_last,
    output logic             scan_en_clk,
    output logic             scan_enable,
    output logic             scan_input
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_load  = 2'd1;
    localparam logic [1:0] st_shift = 2'd2;
    localparam logic [1:0] st_gap   = 2'd3;

    localparam scan_pkg::bit_ptr_t ptr_top = scan_pkg::bit_ptr_t'(scan_pkg::word_width - 1);

    logic [1:0]         state;
    logic               start_q;
    logic               start_fall;
    scan_pkg::bit_ptr_t bit_ptr;
    scan_pkg::bit_ptr_t next_ptr;
    scan_pkg::word_t    bit_cnt;
    scan_pkg::word_t    len;
    scan_pkg::word_t    res_word;
    logic               run_end;
    logic               push_need;
    logic               can_go;
    logic               want_load;
    logic               do_load;

    assign start_fall = start_q & ~scan_start;

    ////////////////////
    // Bit sequencing
    ////////////////////

    // bit_cnt counts bits already driven onto the chain
    assign run_end   = (bit_cnt == len);
    assign push_need = (state == st_gap) && (bit_ptr == '0 || run_end);
    assign can_go    = !push_need || out_ready;

    // Pointer wraps 0 -> 31 at a word boundary
    assign next_ptr  = (state == st_gap) ? bit_ptr - 1'b1 : bit_ptr;
    assign want_load = (state == st_load) || (state == st_gap && can_go && !run_end);
    assign do_load   = want_load && in_valid;

    // Stimulus word leaves the FIFO with its final bit
    assign in_ready  = do_load && (next_ptr == '0 || bit_cnt + 1'b1 == len);

    assign out_valid = push_need;
    assign out_word  = res_word;
    assign out_last  = push_need && run_end;

    always_ff @(posedge aclk or posedge aresetn)
    begin
        if (aresetn)
        begin
            state       <= st_idle;
            start_q     <= 1'b0;
            run_start   <= 1'b0;
            scan_en_clk <= 1'b0;
            scan_enable <= 1'b0;
            scan_input  <= 1'b0;
            bit_ptr     <= ptr_top;
            bit_cnt     <= '0;
        end
        else
        begin
            start_q   <= scan_start;
            run_start <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (start_fall)
                    begin
                        run_start   <= 1'b1;
                        scan_enable <= 1'b1;
                        bit_ptr     <= ptr_top;
                        bit_cnt     <= '0;
                        state       <= st_load;
                    end
                end
                st_shift:
                begin
                    // Capture edge of this bit
                    scan_en_clk <= 1'b0;
                    if (run_end)
                    begin
                        scan_enable <= 1'b0;
                    end
                    state <= st_gap;
                end
                default:
                begin
                    if (do_load)
                    begin
                        scan_input  <= in_word[next_ptr];
                        scan_en_clk <= 1'b1;
                        bit_ptr     <= next_ptr;
                        bit_cnt     <= bit_cnt + 1'b1;
                        state       <= st_shift;
                    end
                    else if (state == st_gap && can_go)
                    begin
                        if (run_end)
                        begin
                            state <= st_idle;
                        end
                        else
                        begin
                            // Stimulus not there yet
                            bit_ptr <= next_ptr;
                            state   <= st_load;
                        end
                    end
                end
            endcase
        end
    end

    // Unused low bits of the final word stay zero
    always_ff @(posedge aclk)
    begin
        if (state == st_idle && start_fall)
        begin
            len      <= scan_length;
            res_word <= '0;
        end
        else if (state == st_shift)
        begin
            res_word[bit_ptr] <= scan_output;
        end
        else if (push_need && out_ready)
        begin
            res_word <= '0;
        end
    end

endmodule

//--- scan_dma_top.sv
module scan_dma_top #(
    parameter int fifo_depth = 2
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  scan_pkg::addr_t  scan_address_src,
    input  scan_pkg::addr_t  scan_address_dst,
    input  scan_pkg::word_t  scan_length,
    input  logic             scan_start,
    input  scan_pkg::word_t  cs_data_i,
    input  logic             cs_done,
    input  logic             scan_output,
    output logic             cs_ready,
    output scan_pkg::addr_t  cs_address,
    output logic             cs_is_read,
    output scan_pkg::word_t  cs_data_o,
    output logic             scan_done,
    output logic             scan_en_clk,
    output logic             scan_enable,
    output logic             scan_input
);

    logic            run_start;
    logic            in_valid;
    logic            in_ready;
    scan_pkg::word_t in_word;
    logic            out_valid;
    logic            out_ready;
    scan_pkg::word_t out_word;
    logic            out_last;

    mem_req_if rd_if ();
    mem_req_if wr_if ();

    scan_shifter u_shifter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .scan_start  (scan_start),
        .scan_length (scan_length),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .out_ready   (out_ready),
        .scan_output (scan_output),
        .run_start   (run_start),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .out_last    (out_last),
        .scan_en_clk (scan_en_clk),
        .scan_enable (scan_enable),
        .scan_input  (scan_input)
    );

    word_fetch #(
        .fifo_depth (fifo_depth)
    ) u_fetch (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .run_start        (run_start),
        .scan_address_src (scan_address_src),
        .scan_length      (scan_length),
        .in_ready         (in_ready),
        .in_valid         (in_valid),
        .in_word          (in_word),
        .mem              (rd_if.client)
    );

    word_store #(
        .fifo_depth (fifo_depth)
    ) u_store (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .run_start        (run_start),
        .scan_address_dst (scan_address_dst),
        .out_valid        (out_valid),
        .out_word         (out_word),
        .out_last         (out_last),
        .out_ready        (out_ready),
        .scan_done        (scan_done),
        .mem              (wr_if.client)
    );

    mem_port_arbiter u_arbiter (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .cs_data_i  (cs_data_i),
        .cs_done    (cs_done),
        .cs_ready   (cs_ready),
        .cs_address (cs_address),
        .cs_is_read (cs_is_read),
        .cs_data_o  (cs_data_o),
        .rd_port    (rd_if.arbiter),
        .wr_port    (wr_if.arbiter)
    );

endmodule

//--- scan_dma_sva.sv
module scan_dma_sva (
    input logic            aclk,
    input logic            aresetn,
    input logic            cs_ready,
    input logic            cs_done,
    input logic            cs_is_read,
    input scan_pkg::addr_t cs_address,
    input logic            scan_en_clk,
    input logic            scan_enable
);

    logic pending;

    // High from the cycle after cs_ready through the cs_done cycle
    always_ff @(posedge aclk or posedge aresetn)
    begin
        if (aresetn)
        begin
            pending <= 1'b0;
        end
        else if (cs_ready)
        begin
            pending <= 1'b1;
        end
        else if (cs_done)
        begin
            pending <= 1'b0;
        end
    end

    ready_pulse: assert property (@(posedge aclk) disable iff (aresetn)
        cs_ready |=> !cs_ready)
        else $error("cs_ready high for more than one cycle");

    access_stable: assert property (@(posedge aclk) disable iff (aresetn)
        pending |-> ($stable(cs_address) && $stable(cs_is_read)))
        else $error("memory access changed before cs_done");

    en_clk_in_run: assert property (@(posedge aclk) disable iff (aresetn)
        scan_en_clk |-> scan_enable)
        else $error("scan_en_clk high while scan_enable low");

endmodule

bind scan_dma_top scan_dma_sva u_sva (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cs_ready    (cs_ready),
    .cs_done     (cs_done),
    .cs_is_read  (cs_is_read),
    .cs_address  (cs_address),
    .scan_en_clk (scan_en_clk),
    .scan_enable (scan_enable)
);

//--- tb_scan_dma.sv
module tb_scan_dma;

    localparam int period      = 20;
    localparam int drive_delay = 2;
    localparam int mem_words   = 256;

    // Lengths of all runs below, for the timeout
    localparam int total_bits  = 20 + 100 + 64 + 32 + 45 + 40;
    localparam int total_words = 1 + 4 + 2 + 1 + 2 + 2;
    localparam int cycle_limit = 4 * total_bits + 40 * total_words + 2000;

    logic            aclk = 1'b0;
    logic            aresetn;
    scan_pkg::addr_t scan_address_src;
    scan_pkg::addr_t scan_address_dst;
    scan_pkg::word_t scan_length;
    logic            scan_start;
    scan_pkg::word_t cs_data_i;
    logic            cs_done;
    logic            scan_output;
    logic            cs_ready;
    scan_pkg::addr_t cs_address;
    logic            cs_is_read;
    scan_pkg::word_t cs_data_o;
    logic            scan_done;
    logic            scan_en_clk;
    logic            scan_enable;
    logic            scan_input;

    logic [6:0]      chain = '0;
    logic [6:0]      chain_state;
    scan_pkg::word_t mem [mem_words];
    scan_pkg::addr_t rd_log [$];
    scan_pkg::addr_t wr_log [$];
    scan_pkg::word_t exp_words [$];
    integer          seed = 20451;
    bit              random_delay;
    int              errors;
    int              test_errors;
    int              tests_run;
    int              tests_failed;
    int              cycles;

    always #(period / 2) aclk = ~aclk;

    scan_dma_top #(
        .fifo_depth (2)
    ) i_dut (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .scan_address_src (scan_address_src),
        .scan_address_dst (scan_address_dst),
        .scan_length      (scan_length),
        .scan_start       (scan_start),
        .cs_data_i        (cs_data_i),
        .cs_done          (cs_done),
        .scan_output      (scan_output),
        .cs_ready         (cs_ready),
        .cs_address       (cs_address),
        .cs_is_read       (cs_is_read),
        .cs_data_o        (cs_data_o),
        .scan_done        (scan_done),
        .scan_en_clk      (scan_en_clk),
        .scan_enable      (scan_enable),
        .scan_input       (scan_input)
    );

    ////////////////////
    // Scan chain, 7 stages
    ////////////////////

    always @(posedge aclk or posedge aresetn)
    begin
        if (aresetn)
        begin
            chain <= '0;
        end
        else if (scan_en_clk)
        begin
            chain <= {chain[5:0], scan_input};
        end
    end

    assign scan_output = chain[6];

    task automatic next_cycle();
        @(posedge aclk);
        #drive_delay;
    endtask

    ////////////////////
    // Memory model
    ////////////////////

    initial
    begin : memory_model
        scan_pkg::addr_t acc_addr;
        logic            acc_read;
        scan_pkg::word_t acc_data;
        int              index;
        int              delay;
        forever
        begin
            next_cycle();
            if (cs_ready === 1'b1)
            begin
                acc_addr = cs_address;
                acc_read = cs_is_read;
                acc_data = cs_data_o;
                index    = acc_addr[9:2];
                if (acc_addr >= mem_words * 4)
                begin
                    $display("Memory access outside the model at address %h", acc_addr);
                    errors++;
                end
                delay = random_delay ? 1 + ($random(seed) & 7) : 1;
                repeat (delay) next_cycle();
                if (acc_read)
                begin
                    cs_data_i = mem[index];
                    rd_log.push_back(acc_addr);
                end
                else
                begin
                    mem[index] = acc_data;
                    wr_log.push_back(acc_addr);
                end
                cs_done = 1'b1;
                next_cycle();
                cs_done = 1'b0;
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge aclk);
            cycles++;
        end
        $display("Run did not finish: still busy after %0d clock cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Stream bit j, MSB first through the source words
    function automatic logic stim_bit(input int src_index, input int j);
        scan_pkg::bit_ptr_t pos;
        pos = scan_pkg::bit_ptr_t'(31 - (j % 32));
        return mem[src_index + j / 32][pos];
    endfunction

    // Captured bit k is old chain bit for k < 7, else stimulus bit k - 7
    function automatic scan_pkg::word_t expected_word(input logic [6:0] old_chain,
                                                      input int src_index,
                                                      input int len,
                                                      input int w);
        scan_pkg::word_t    word;
        scan_pkg::bit_ptr_t pos;
        int                 b;
        int                 k;
        word = '0;
        for (b = 0; b < 32; b++)
        begin
            k   = w * 32 + b;
            pos = scan_pkg::bit_ptr_t'(31 - b);
            if (k < len)
            begin
                word[pos] = (k < 7) ? old_chain[6 - k] : stim_bit(src_index, k - 7);
            end
        end
        return word;
    endfunction

    function automatic logic [6:0] chain_after(input logic [6:0] old_chain,
                                               input int src_index,
                                               input int len);
        logic [6:0] c;
        int         j;
        c = old_chain;
        for (j = 0; j < len; j++)
        begin
            c = {c[5:0], stim_bit(src_index, j)};
        end
        return c;
    endfunction

    task automatic check_value(input scan_pkg::word_t actual,
                               input scan_pkg::word_t expected,
                               input string msg);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_errors)
        begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic compare_result(input scan_pkg::addr_t src,
                                  input scan_pkg::addr_t dst,
                                  input int nw);
        int i;
        check_value(rd_log.size(), nw, "number of source reads");
        check_value(wr_log.size(), nw, "number of destination writes");
        for (i = 0; i < nw; i++)
        begin
            if (i < rd_log.size())
            begin
                check_value(rd_log[i], src + 4 * i,
                            $sformatf("address of read %0d", i));
            end
            if (i < wr_log.size())
            begin
                check_value(wr_log[i], dst + 4 * i,
                            $sformatf("address of write %0d", i));
            end
            check_value(mem[dst / 4 + i], exp_words[i], $sformatf("result word %0d", i));
        end
    endtask

    task automatic run_scan(input scan_pkg::addr_t src,
                            input scan_pkg::addr_t dst,
                            input int len,
                            input bit glitch);
        int nw;
        int i;
        nw = (len + 31) / 32;
        exp_words.delete();
        rd_log.delete();
        wr_log.delete();
        for (i = 0; i < nw; i++)
        begin
            exp_words.push_back(expected_word(chain_state, src / 4, len, i));
        end
        scan_address_src = src;
        scan_address_dst = dst;
        scan_length      = len;
        next_cycle();
        scan_start = 1'b0;
        next_cycle();
        scan_start = 1'b1;
        repeat (3) next_cycle();
        check_value(scan_done, 1'b0, "scan_done cleared by start");
        // Run parameters only matter at the start
        scan_address_src = src ^ 'h100;
        scan_address_dst = dst ^ 'h100;
        scan_length      = len + 1;
        if (glitch)
        begin
            // Second fall while shifting
            repeat (6) next_cycle();
            scan_start = 1'b0;
            next_cycle();
            scan_start = 1'b1;
        end
        while (!scan_done)
        begin
            next_cycle();
        end
        chain_state = chain_after(chain_state, src / 4, len);
        compare_result(src, dst, nw);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    initial
    begin : main
        int i;
        aresetn          = 1'b1;
        scan_start       = 1'b1;
        scan_address_src = '0;
        scan_address_dst = '0;
        scan_length      = '0;
        cs_data_i        = '0;
        cs_done          = 1'b0;
        random_delay     = 1'b0;
        errors           = 0;
        test_errors      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        chain_state      = '0;
        for (i = 0; i < mem_words; i++)
        begin
            mem[i] = 32'h5a5a0000 ^ (i * 32'h00010001);
        end
        // Source area, first 32 words
        for (i = 0; i < 32; i++)
        begin
            mem[i] = $random(seed);
        end
        repeat (8) @(posedge aclk);
        #drive_delay;
        aresetn = 1'b0;

        check_value(cs_ready, 1'b0, "cs_ready after reset");
        check_value(scan_en_clk, 1'b0, "scan_en_clk after reset");
        check_value(scan_enable, 1'b0, "scan_enable after reset");
        check_value(scan_done, 1'b0, "scan_done after reset");
        repeat (20)
        begin
            next_cycle();
            check_value(cs_ready, 1'b0, "cs_ready without a start");
        end
        check_value(rd_log.size() + wr_log.size(), 0, "memory accesses without a start");
        finish_test("idle after reset");

        run_scan('h000, 'h200, 20, 1'b0);
        finish_test("20 bits, fixed delay");

        run_scan('h010, 'h220, 100, 1'b0);
        finish_test("100 bits, four words");

        random_delay = 1'b1;
        run_scan('h030, 'h240, 64, 1'b0);
        random_delay = 1'b0;
        finish_test("64 bits, random delay");

        run_scan('h040, 'h260, 32, 1'b0);
        run_scan('h050, 'h280, 45, 1'b0);
        check_value(mem['h280 / 4][31:25], mem['h040 / 4][6:0],
                    "first seven bits of second run");
        finish_test("back-to-back 32 and 45 bits");

        run_scan('h060, 'h2a0, 40, 1'b1);
        repeat (30) next_cycle();
        check_value(rd_log.size(), 2, "reads after ignored start");
        check_value(wr_log.size(), 2, "writes after ignored start");
        check_value(scan_enable, 1'b0, "scan_enable after ignored start");
        finish_test("start during a run");

        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
scan_pkg.sv
mem_req_if.sv
scan_word_fifo.sv
word_fetch.sv
word_store.sv
mem_port_arbiter.sv
scan_shifter.sv
scan_dma_top.sv
scan_dma_sva.sv
tb_scan_dma.sv
